// File: hw/mips_consts.svh
// MIPS core constants for datapath widths, memory depth and the APB address map
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// --------------------
// Widths
// --------------------
`define DATA_W   32   // Data word
`define REG_AW   5    // 32 registers
`define IMEM_AW  6    // 64 instruction words
`define APB_AW   12   // Host address bus

// --------------------
// APB map, byte addresses
// --------------------
`define IMEM_BASE 12'h000   // Instruction words 0x000..0x0FC
`define CTRL_ADDR 12'h100   // Bit 0 starts the core
`define STAT_ADDR 12'h104   // Bit 31 halted, low bits PC
`define REG_BASE  12'h200   // Register readback 0x200..0x27C

`endif

// File: hw/mipsPkg.sv
// MIPS subset package with the opcode, function-code, ALU and controller-state enums
package mipsPkg;

  // --------------------
  // Instruction encodings
  // --------------------

  // Primary opcode, bits 31:26 of the instruction
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,  // ALU op chosen by funct field
    OP_J     = 6'h02,  // Absolute word jump
    OP_BEQ   = 6'h04,  // Branch on equal, offset from PC+1
    OP_ADDI  = 6'h08,  // Sign-extended immediate
    OP_ORI   = 6'h0D,  // Zero-extended immediate
    OP_HALT  = 6'h3F   // Reserved value, stops the core
  } opcodeT;

  // Function code, bits 5:0 of an R-type instruction
  typedef enum logic [5:0] {
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_SLT = 6'h2A   // Signed compare
  } functT;

  // --------------------
  // Datapath control
  // --------------------

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } aluOpT;

  // Three cycles per instruction, halted flag kept apart from the state
  typedef enum logic [1:0] {ST_IDLE, ST_FETCH, ST_EXEC, ST_WBACK} ctrlStateT;

endpackage

// File: hw/regFile.sv
// Register file, 32x32 with two combinational reads, one clocked write and a zero register
`timescale 1ns/100ps
`include "mips_consts.svh"

module regFile (
  input  logic              clk,
  input  logic [`REG_AW-1:0] readAddr1,   // rs, or host index when idle
  input  logic [`REG_AW-1:0] readAddr2,   // rt
  output logic [`DATA_W-1:0] readData1,
  output logic [`DATA_W-1:0] readData2,
  input  logic [`REG_AW-1:0] writeAddr,
  input  logic [`DATA_W-1:0] writeData,
  input  logic              writeEn
);

  // Storage, entry 0 never written
  logic [`DATA_W-1:0] regs [2**`REG_AW];

  logic writeOk;   // Write enable with register 0 masked

  assign writeOk = writeEn && (writeAddr != '0);

  // --------------------
  // Write port
  // --------------------
  always_ff @(posedge clk) begin
    if (writeOk) begin
      regs[writeAddr] <= writeData;   // Visible from the next cycle
    end
  end

  // --------------------
  // Read ports
  // --------------------
  // Address 0 reads zero whatever the array holds
  assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
  assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

// File: hw/alu.sv
// ALU for the MIPS subset, add, subtract, logic and signed set-less-than with zero flag
`timescale 1ns/100ps
`include "mips_consts.svh"

module alu (
  input  logic [`DATA_W-1:0] a,
  input  logic [`DATA_W-1:0] b,
  input  mipsPkg::aluOpT     op,
  output logic [`DATA_W-1:0] result,
  output logic               zero     // Used with SUB for BEQ
);

  import mipsPkg::*;

  logic lessThan;   // Signed a < b

  assign lessThan = $signed(a) < $signed(b);

  // --------------------
  // Operation select
  // --------------------
  always_comb begin
    case (op)
      ALU_ADD: begin
        result = a + b;
      end
      ALU_SUB: begin
        result = a - b;   // Also the BEQ compare
      end
      ALU_AND: begin
        result = a & b;
      end
      ALU_OR: begin
        result = a | b;
      end
      ALU_SLT: begin
        // 1 or 0 in the low bit
        result = {{(`DATA_W-1){1'b0}}, lessThan};
      end
      default: begin
        result = '0;
      end
    endcase
  end

  assign zero = (result == '0);   // Equal operands under SUB

endmodule

// File: hw/instrMem.sv
// Instruction memory, 64 words, registered core fetch port and host write/readback port
`timescale 1ns/100ps
`include "mips_consts.svh"

module instrMem (
  input  logic                clk,
  // Core side
  input  logic [`IMEM_AW-1:0] fetchAddr,      // Word address, the PC
  input  logic                fetchEn,        // High in FETCH only
  output logic [`DATA_W-1:0]  fetchData,      // Held while fetchEn is low
  // Host side
  input  logic                hostWriteEn,
  input  logic [`IMEM_AW-1:0] hostAddr,
  input  logic [`DATA_W-1:0]  hostWriteData,
  output logic [`DATA_W-1:0]  hostReadData
);

  logic [`DATA_W-1:0] mem [2**`IMEM_AW];   // Program words

  // --------------------
  // Host port
  // --------------------
  always_ff @(posedge clk) begin
    if (hostWriteEn) begin
      mem[hostAddr] <= hostWriteData;   // Loads only while core is idle
    end
  end

  // Combinational readback for APB
  assign hostReadData = mem[hostAddr];

  // --------------------
  // Fetch port
  // --------------------
  // One cycle latency, word is ready for EXEC
  always_ff @(posedge clk) begin
    if (fetchEn) begin
      fetchData <= mem[fetchAddr];
    end
  end

endmodule

// File: hw/coreCtrl.sv
// Core controller holding the multicycle FSM, PC, instruction decode and the APB slave
`timescale 1ns/100ps
`include "mips_consts.svh"

module coreCtrl (
  input  logic                clk,
  input  logic                rstN,
  // APB slave
  input  logic [`APB_AW-1:0]  paddr,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [`DATA_W-1:0]  pwdata,
  output logic [`DATA_W-1:0]  prdata,
  output logic                pready,
  output logic                pslverr,
  // Register file
  output logic [`REG_AW-1:0]  readAddr1,
  output logic [`REG_AW-1:0]  readAddr2,
  input  logic [`DATA_W-1:0]  readData1,
  input  logic [`DATA_W-1:0]  readData2,
  output logic [`REG_AW-1:0]  writeAddr,
  output logic [`DATA_W-1:0]  writeData,
  output logic                writeEn,
  // ALU
  output logic [`DATA_W-1:0]  aluA,
  output logic [`DATA_W-1:0]  aluB,
  output mipsPkg::aluOpT      aluOp,
  input  logic [`DATA_W-1:0]  aluResult,
  input  logic                aluZero,
  // Instruction memory
  output logic [`IMEM_AW-1:0] fetchAddr,
  output logic                fetchEn,
  input  logic [`DATA_W-1:0]  fetchData,
  output logic                hostWriteEn,
  output logic [`IMEM_AW-1:0] hostAddr,
  output logic [`DATA_W-1:0]  hostWriteData,
  input  logic [`DATA_W-1:0]  hostReadData
);

  import mipsPkg::*;

  // Region masks where the low bits index the word
  localparam logic [`APB_AW-1:0] imemMask = ~`APB_AW'((2**(`IMEM_AW+2))-1);
  localparam logic [`APB_AW-1:0] regMask  = ~`APB_AW'((2**(`REG_AW+2))-1);

  ctrlStateT          state;
  logic [`IMEM_AW-1:0] pc, execNextPc, nextPcReg;
  logic               halted, running;
  logic [`DATA_W-1:0] instrReg, resultReg;   // Held from EXEC into WBACK
  logic [`DATA_W-1:0] signExt, zeroExt;
  opcodeT             execOp, wbOp;
  functT              execFn;
  logic               access, imemSel, ctrlSel, statSel, regSel, startCmd;

  // --------------------
  // APB decode
  // --------------------
  assign pready   = 1'b1;                     // No wait states
  assign access   = psel && penable;
  assign running  = (state != ST_IDLE);
  assign imemSel  = (paddr & imemMask) == `IMEM_BASE;
  assign regSel   = (paddr & regMask) == `REG_BASE;
  assign ctrlSel  = (paddr == `CTRL_ADDR);
  assign statSel  = (paddr == `STAT_ADDR);
  assign startCmd = access && pwrite && ctrlSel && pwdata[0];   // Ignored when running

  assign hostAddr      = paddr[`IMEM_AW+1:2];
  assign hostWriteData = pwdata;
  assign hostWriteEn   = access && pwrite && imemSel && !running;   // Refused while running

  // Refused accesses and holes in the map
  assign pslverr = access && ((imemSel && pwrite && running) ||
                              (regSel && !pwrite && running) ||
                              !(imemSel || regSel || ctrlSel || statSel));

  always_comb begin
    if (imemSel)      prdata = hostReadData;
    else if (ctrlSel) prdata = {{(`DATA_W-1){1'b0}}, running};
    else if (statSel) prdata = {halted, {(`DATA_W-1-`IMEM_AW){1'b0}}, pc};
    else if (regSel)  prdata = readData1;   // Host index on port 1 when idle
    else              prdata = '0;
  end

  // --------------------
  // EXEC decode
  // --------------------
  assign execOp  = opcodeT'(fetchData[31:26]);
  assign execFn  = functT'(fetchData[5:0]);
  assign signExt = {{(`DATA_W-16){fetchData[15]}}, fetchData[15:0]};   // ADDI
  assign zeroExt = {{(`DATA_W-16){1'b0}}, fetchData[15:0]};            // ORI

  assign readAddr1 = running ? fetchData[25:21] : paddr[`REG_AW+1:2];   // rs or host index
  assign readAddr2 = fetchData[20:16];                                   // rt
  assign aluA      = readData1;

  always_comb begin
    aluOp = ALU_ADD;
    aluB  = readData2;
    case (execOp)
      OP_RTYPE: begin
        case (execFn)
          FN_SUB:  aluOp = ALU_SUB;
          FN_AND:  aluOp = ALU_AND;
          FN_OR:   aluOp = ALU_OR;
          FN_SLT:  aluOp = ALU_SLT;
          default: aluOp = ALU_ADD;
        endcase
      end
      OP_ADDI: aluB = signExt;
      OP_ORI: begin
        aluOp = ALU_OR;
        aluB  = zeroExt;
      end
      OP_BEQ:  aluOp = ALU_SUB;   // Zero flag means equal
      default: ;
    endcase
  end

  // Next PC with word offsets wrapping at memory depth
  always_comb begin
    case (execOp)
      OP_BEQ:  execNextPc = aluZero ? pc + `IMEM_AW'(1) + fetchData[`IMEM_AW-1:0]
                                    : pc + `IMEM_AW'(1);
      OP_J:    execNextPc = fetchData[`IMEM_AW-1:0];
      default: execNextPc = pc + `IMEM_AW'(1);
    endcase
  end

  always_ff @(posedge clk) begin
    if (state == ST_EXEC) begin
      instrReg  <= fetchData;
      resultReg <= aluResult;
      nextPcReg <= execNextPc;
    end
  end

  // --------------------
  // WBACK and FSM
  // --------------------
  assign wbOp      = opcodeT'(instrReg[31:26]);
  assign writeAddr = (wbOp == OP_RTYPE) ? instrReg[15:11] : instrReg[20:16];   // rd or rt
  assign writeData = resultReg;
  assign writeEn   = (state == ST_WBACK) &&
                     (wbOp == OP_RTYPE || wbOp == OP_ADDI || wbOp == OP_ORI);
  assign fetchAddr = pc;
  assign fetchEn   = (state == ST_FETCH);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state  <= ST_IDLE;
      pc     <= '0;
      halted <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (startCmd) begin
            state  <= ST_FETCH;   // Run from word 0
            pc     <= '0;
            halted <= 1'b0;
          end
        end
        ST_FETCH: state <= ST_EXEC;
        ST_EXEC:  state <= ST_WBACK;
        ST_WBACK: begin
          if (wbOp == OP_HALT) begin
            halted <= 1'b1;       // PC stays on the HALT word
            state  <= ST_IDLE;
          end else begin
            pc    <= nextPcReg;
            state <= ST_FETCH;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: hw/mipsCore.sv
// MIPS core top level, joins the controller with register file, ALU and instruction memory
`timescale 1ns/100ps
`include "mips_consts.svh"

module mipsCore (
  input  logic               clk,
  input  logic               rstN,
  input  logic [`APB_AW-1:0] paddr,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [`DATA_W-1:0] pwdata,
  output logic [`DATA_W-1:0] prdata,
  output logic               pready,
  output logic               pslverr
);

  import mipsPkg::*;

  // --------------------
  // Internal nets
  // --------------------
  logic [`REG_AW-1:0]  readAddr1, readAddr2, writeAddr;
  logic [`DATA_W-1:0]  readData1, readData2, writeData;
  logic                writeEn;
  logic [`DATA_W-1:0]  aluA, aluB, aluResult;
  aluOpT               aluOp;
  logic                aluZero;
  logic [`IMEM_AW-1:0] fetchAddr, hostAddr;
  logic                fetchEn, hostWriteEn;
  logic [`DATA_W-1:0]  fetchData, hostWriteData, hostReadData;

  // Controller and host port
  coreCtrl ctrl0 (
    .clk, .rstN,
    .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
    .readAddr1, .readAddr2, .readData1, .readData2,
    .writeAddr, .writeData, .writeEn,
    .aluA, .aluB, .aluOp, .aluResult, .aluZero,
    .fetchAddr, .fetchEn, .fetchData,
    .hostWriteEn, .hostAddr, .hostWriteData, .hostReadData
  );

  regFile regs0 (
    .clk,
    .readAddr1, .readAddr2, .readData1, .readData2,
    .writeAddr, .writeData, .writeEn
  );

  alu alu0 (
    .a      (aluA),
    .b      (aluB),
    .op     (aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  instrMem imem0 (
    .clk,
    .fetchAddr, .fetchEn, .fetchData,
    .hostWriteEn, .hostAddr, .hostWriteData, .hostReadData
  );

endmodule

// File: verif/mipsCoreChecks.sv
// MIPS core checker that shadows the APB traffic, interprets the program and asserts on readback
`timescale 1ns/100ps
`include "mips_consts.svh"

module mipsCoreChecks (
  input  logic               clk,
  input  logic               rstN,
  input  logic [`APB_AW-1:0] paddr,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [`DATA_W-1:0] pwdata,
  input  logic [`DATA_W-1:0] prdata,
  input  logic               pready,
  input  logic               pslverr,
  output int                 errCount
);

  import mipsPkg::*;

  logic [`DATA_W-1:0]  shadow [2**`IMEM_AW];   // Program as the host loaded it
  logic [`DATA_W-1:0]  expRegs [2**`REG_AW];   // Interpreter register state
  logic [`IMEM_AW-1:0] expPc;                  // PC of the HALT word
  int                  expCount;               // Executed instructions including HALT
  logic                busy;                   // Core started and halt not yet seen
  int                  cyc;                    // Cycles since the start write
  logic                imemHit, regHit, mapped, expErr;

  initial begin
    for (int i = 0; i < 2**`REG_AW; i++) expRegs[i] = '0;
    busy = 1'b0;
    cyc = 0;
    errCount = 0;
  end

  // --------------------
  // Reference interpreter
  // --------------------
  task automatic interpret();
    logic [`IMEM_AW-1:0] pc;
    logic [`DATA_W-1:0]  ir, a, b, r;
    opcodeT              op;
    int                  n;
    pc = '0;
    n = 0;
    while (n < 1000) begin   // Guard against a program that never halts
      ir = shadow[pc];
      n++;
      op = opcodeT'(ir[31:26]);
      a = expRegs[ir[25:21]];
      b = expRegs[ir[20:16]];
      if (op == OP_HALT) break;
      case (op)
        OP_RTYPE: begin
          case (functT'(ir[5:0]))
            FN_SUB:  r = a - b;
            FN_AND:  r = a & b;
            FN_OR:   r = a | b;
            FN_SLT:  r = ($signed(a) < $signed(b)) ? 1 : 0;
            default: r = a + b;
          endcase
          if (ir[15:11] != 0) expRegs[ir[15:11]] = r;   // Zero register stays 0
          pc++;
        end
        OP_ADDI: begin
          // Sign-extended
          if (ir[20:16] != 0) expRegs[ir[20:16]] = a + {{16{ir[15]}}, ir[15:0]};
          pc++;
        end
        OP_ORI: begin
          if (ir[20:16] != 0) expRegs[ir[20:16]] = a | {16'h0, ir[15:0]};   // Zero-extended
          pc++;
        end
        OP_BEQ:  pc = (a == b) ? pc + 1 + ir[`IMEM_AW-1:0] : pc + 1;   // Offset from PC+1
        OP_J:    pc = ir[`IMEM_AW-1:0];
        default: pc++;
      endcase
    end
    expPc = pc;
    expCount = n;
  endtask

  // --------------------
  // APB access checks
  // --------------------
  assign imemHit = (paddr < `CTRL_ADDR);
  assign regHit  = (paddr >= `REG_BASE) && (paddr < `REG_BASE + 12'h080);
  assign mapped  = imemHit || regHit || (paddr == `CTRL_ADDR) || (paddr == `STAT_ADDR);
  // Refused cases
  assign expErr  = !mapped || (busy && ((imemHit && pwrite) || (regHit && !pwrite)));

  // Every access phase completes at once
  assert property (@(posedge clk) disable iff (!rstN) (psel && penable) |-> pready)
    else begin
      $display("Mismatch pready exp 1 got %h", pready);
      errCount++;
    end

  always @(posedge clk) begin
    if (rstN && psel && penable) begin
      assert (pslverr == expErr) else begin
        $display("Mismatch pslverr at %h exp %h got %h", paddr, expErr, pslverr);
        errCount++;
      end
      if (imemHit && pwrite && !expErr) shadow[paddr[`IMEM_AW+1:2]] = pwdata;
      if (imemHit && !pwrite) begin
        assert (prdata == shadow[paddr[`IMEM_AW+1:2]]) else begin
          $display("Mismatch prdata imem[%0d] exp %h got %h", paddr[`IMEM_AW+1:2],
                   shadow[paddr[`IMEM_AW+1:2]], prdata);
          errCount++;
        end
      end
      if (regHit && !pwrite && !busy) begin
        assert (prdata == expRegs[paddr[`REG_AW+1:2]]) else begin
          $display("Mismatch prdata reg%0d exp %h got %h", paddr[`REG_AW+1:2],
                   expRegs[paddr[`REG_AW+1:2]], prdata);
          errCount++;
        end
      end
      if (paddr == `CTRL_ADDR && pwrite && pwdata[0] && !busy) begin
        interpret();   // Expected results of the program as loaded now
        busy = 1'b1;
        cyc = 0;
      end else if (paddr == `STAT_ADDR && !pwrite && busy && prdata[31]) begin
        assert (prdata[`IMEM_AW-1:0] == expPc) else begin
          $display("Mismatch status pc exp %h got %h", expPc, prdata[`IMEM_AW-1:0]);
          errCount++;
        end
        assert (cyc <= 3 * expCount + 4) else begin
          $display("Halt came too late, %0d cycles for %0d instructions", cyc, expCount);
          errCount++;
        end
        busy = 1'b0;
      end
    end
    if (busy) cyc++;
  end

endmodule

// File: verif/mipsCoreTb.sv
// MIPS core testbench, loads programs over APB, runs them and reads back the results
`timescale 1ns/100ps
`include "mips_consts.svh"

module mipsCoreTb;

  import mipsPkg::*;

  localparam int numProgs = 2;
  // Instruction budget per program plus APB load and readback traffic
  localparam int wdCycles = numProgs * (64 * 3 + 200) + 3 * 600;

  logic               clk, rstN;
  logic [`APB_AW-1:0] paddr;
  logic               psel, penable, pwrite;
  logic [`DATA_W-1:0] pwdata, prdata, rdData;
  logic               pready, pslverr;
  logic [`DATA_W-1:0] prog [$];
  int                 checkErrors, tbErrors;

  always #50 clk = ~clk;   // 100 ns period

  mipsCore dut0 (.clk, .rstN, .paddr, .psel, .penable, .pwrite, .pwdata,
                 .prdata, .pready, .pslverr);

  mipsCoreChecks checks0 (.clk, .rstN, .paddr, .psel, .penable, .pwrite, .pwdata,
                          .prdata, .pready, .pslverr, .errCount(checkErrors));

  // --------------------
  // Encoders and APB
  // --------------------
  function automatic logic [31:0] encodeR(functT fn, logic [4:0] rd, rs, rt);
    return {6'h00, rs, rt, rd, 5'h00, fn};
  endfunction

  function automatic logic [31:0] encodeI(opcodeT op, logic [4:0] rt, rs, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic apbWrite(logic [`APB_AW-1:0] addr, logic [`DATA_W-1:0] data);
    @(posedge clk);
    paddr <= addr;   // Setup phase
    pwrite <= 1'b1;
    pwdata <= data;
    psel <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;   // Access phase
    @(posedge clk);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apbRead(logic [`APB_AW-1:0] addr, output logic [`DATA_W-1:0] data);
    @(posedge clk);
    paddr <= addr;
    pwrite <= 1'b0;
    psel <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    data = prdata;   // Pre-edge value of the access cycle
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic loadProgram();
    foreach (prog[i]) apbWrite(`IMEM_BASE + 12'(i * 4), prog[i]);
  endtask

  task automatic waitHalted();
    logic [`DATA_W-1:0] stat;
    int polls;
    polls = 0;
    stat = '0;
    while (!stat[31] && polls < 200) begin
      apbRead(`STAT_ADDR, stat);
      polls++;
    end
    if (!stat[31]) begin
      $display("Core did not halt within %0d status polls", polls);
      tbErrors++;
    end
  endtask

  task automatic readAllRegs();
    for (int r = 0; r < 32; r++) apbRead(`REG_BASE + 12'(r * 4), rdData);
  endtask

  // --------------------
  // Watchdog
  // --------------------
  initial begin
    repeat (wdCycles) @(posedge clk);
    $display("Timeout after %0d cycles, the tests did not finish", wdCycles);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    void'($urandom(32'hb9af5a19));   // One seed for the whole run
    clk = 1'b0;
    rstN = 1'b0;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    tbErrors = 0;
    repeat (3) @(posedge clk);
    rstN <= 1'b1;

    // Fill and read back every instruction word
    for (int i = 0; i < 64; i++) apbWrite(12'(i * 4), 32'h5a00_0000 ^ (i * 32'h0103_0507));
    for (int i = 0; i < 64; i++) apbRead(12'(i * 4), rdData);

    // Random ALU program, every register set first
    for (int r = 1; r < 32; r++) prog.push_back(encodeI(OP_ORI, 5'(r), 5'd0, 16'($urandom)));
    for (int k = 0; k < 18; k++) begin
      case ($urandom % 7)
        0: prog.push_back(encodeR(FN_ADD, 5'($urandom), 5'($urandom), 5'($urandom)));
        1: prog.push_back(encodeR(FN_SUB, 5'($urandom), 5'($urandom), 5'($urandom)));
        2: prog.push_back(encodeR(FN_AND, 5'($urandom), 5'($urandom), 5'($urandom)));
        3: prog.push_back(encodeR(FN_OR, 5'($urandom), 5'($urandom), 5'($urandom)));
        4: prog.push_back(encodeR(FN_SLT, 5'($urandom), 5'($urandom), 5'($urandom)));
        5: prog.push_back(encodeI(OP_ADDI, 5'($urandom), 5'($urandom), 16'($urandom)));
        default: prog.push_back(encodeI(OP_ORI, 5'($urandom), 5'($urandom), 16'($urandom)));
      endcase
    end
    prog.push_back(encodeI(OP_ADDI, 5'd0, 5'd1, 16'h0007));   // Target register 0
    prog.push_back({OP_HALT, 26'h0});
    loadProgram();
    apbWrite(`CTRL_ADDR, 32'h1);
    waitHalted();
    readAllRegs();

    // Counted loop with BEQ and J
    prog.delete();
    prog.push_back(encodeI(OP_ORI, 5'd1, 5'd0, 16'd5));      // Loop counter
    prog.push_back(encodeI(OP_ORI, 5'd2, 5'd0, 16'd0));
    prog.push_back(encodeI(OP_ADDI, 5'd2, 5'd2, 16'd3));     // Loop body
    prog.push_back(encodeI(OP_ADDI, 5'd1, 5'd1, 16'hffff));
    prog.push_back(encodeI(OP_BEQ, 5'd0, 5'd1, 16'd1));      // Exit to word 6
    prog.push_back({OP_J, 26'd2});
    prog.push_back({OP_J, 26'd8});
    prog.push_back(encodeI(OP_ORI, 5'd3, 5'd0, 16'hdead));   // Skipped
    prog.push_back({OP_HALT, 26'h0});
    loadProgram();
    apbWrite(`CTRL_ADDR, 32'h1);
    apbWrite(12'h000, 32'hffff_ffff);   // Refused while running
    apbRead(`REG_BASE + 12'h004, rdData);
    apbRead(12'h300, rdData);           // Hole in the map
    waitHalted();
    readAllRegs();
    apbRead(12'h000, rdData);
    apbRead(12'h304, rdData);

    repeat (2) @(posedge clk);
    $display("Errors: checker %0d, testbench %0d", checkErrors, tbErrors);
    if (checkErrors + tbErrors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: mipsCore.f
+incdir+hw
hw/mipsPkg.sv
hw/regFile.sv
hw/alu.sv
hw/instrMem.sv
hw/coreCtrl.sv
hw/mipsCore.sv
verif/mipsCoreChecks.sv
verif/mipsCoreTb.sv

// File: Makefile
# Verilator build and run for the MIPS core testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f mipsCore.f --top-module mipsCoreTb -Mdir obj_dir

run: compile
	./obj_dir/VmipsCoreTb | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
